// File: opm_bus_pkg.sv
`default_nettype none

package opm_bus_pkg;

    ////////////////////////////////////////
    // host bus constants

    localparam int BUS_W       = 8;     // cpu data bus width
    localparam int BUSY_CYCLES = 32;    // write busy window in clocks

    ////////////////////////////////////////
    // synchronized load pulses

    // one-cycle strobes plus the latched bus byte
    typedef struct packed {
        logic              addr_ld;
        logic              data_ld;
        logic [BUS_W-1:0]  data;
    } bus_load_t;

    // low register addresses, used as opcodes by the decoder
    typedef enum logic [BUS_W-1:0] {
        LO_NOISE      = 8'h0F,
        LO_CLKA1      = 8'h10,  // timer A upper bits
        LO_CLKA2      = 8'h11,  // timer A lower bits
        LO_CLKB       = 8'h12,
        LO_TIMER_CTRL = 8'h14,
        LO_LFRQ       = 8'h18,
        LO_PMD_AMD    = 8'h19,  // d7 picks pmd or amd
        LO_WAVE       = 8'h1B
    } lo_addr_e;

endpackage

`default_nettype wire

// File: opm_reg_pkg.sv
`default_nettype none

package opm_reg_pkg;

    ////////////////////////////////////////
    // channel block

    localparam int         NUM_CH        = 8;
    localparam int         CH_W          = 3;       // channel number bits
    localparam logic [7:0] CH_BLOCK_BASE = 8'h20;   // 0x20-0x3F

    // address bits [4:3] inside the channel block
    typedef enum logic [1:0] {
        FLD_CONNECT = 2'd0,     // rl / fl / alg
        FLD_KC      = 2'd1,
        FLD_KF      = 2'd2,
        FLD_PMS_AMS = 2'd3
    } ch_field_e;

    typedef struct packed {
        logic [1:0] rl;     // right/left enable
        logic [2:0] fl;     // feedback level
        logic [2:0] alg;
        logic [6:0] kc;     // key code
        logic [5:0] kf;     // key fraction
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_params_t;

    ////////////////////////////////////////
    // global registers

    typedef struct packed {
        logic [7:0] clka1;
        logic [1:0] clka2;
        logic [7:0] clkb;
        logic       run_a;
        logic       run_b;
        logic       irq_en_a;
        logic       irq_en_b;
    } timer_regs_t;

    typedef struct packed {
        logic frst_a;
        logic frst_b;
    } timer_frst_t;

    typedef struct packed {
        logic [7:0] lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;      // lfo waveform
    } lfo_regs_t;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
    } noise_regs_t;

endpackage

`default_nettype wire

// File: opm_bus_sync.sv
`default_nettype none
`timescale 1ns/10ps

module opm_bus_sync (
    input  wire                             i_EMUCLK,
    input  wire                             mrst_n,
    input  wire                             i_cs_n,
    input  wire                             i_wr_n,
    input  wire                             i_a0,
    input  wire [opm_bus_pkg::BUS_W-1:0]    i_d,
    output opm_bus_pkg::bus_load_t          o_bus_ld
);

////////////////////////////////////////
// bus capture

logic                           wr_act;     // cs and wr both low
logic                           wr_act_q;
logic                           wr_start;
logic [opm_bus_pkg::BUS_W-1:0]  bus_byte;
logic                           areg_rq;
logic                           dreg_rq;
logic [2:0]                     areg_sync;  // [1:0] synchronizer, [2] edge
logic [2:0]                     dreg_sync;

assign wr_act   = ~(i_cs_n | i_wr_n);
assign wr_start = wr_act & ~wr_act_q;       // first sampled clock only

// byte follows the bus while the strobe is held
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        bus_byte <= '0;
    end else if (wr_act) begin
        bus_byte <= i_d;
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        wr_act_q <= 1'b0;
        areg_rq  <= 1'b0;
        dreg_rq  <= 1'b0;
    end else begin
        wr_act_q <= wr_act;

        if (wr_start && !i_a0) areg_rq <= 1'b1;
        else if (areg_sync[1]) areg_rq <= 1'b0;     // cleared by its own pulse

        if (wr_start && i_a0) dreg_rq <= 1'b1;
        else if (dreg_sync[1]) dreg_rq <= 1'b0;
    end
end

////////////////////////////////////////
// synchronizer and pulse

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        areg_sync <= '0;
        dreg_sync <= '0;
    end else begin
        areg_sync <= {areg_sync[1:0], areg_rq};
        dreg_sync <= {dreg_sync[1:0], dreg_rq};
    end
end

always_comb begin
    o_bus_ld.addr_ld = areg_sync[1] & ~areg_sync[2];
    o_bus_ld.data_ld = dreg_sync[1] & ~dreg_sync[2];
    o_bus_ld.data    = bus_byte;
end

endmodule

`default_nettype wire

// File: opm_lo_regs.sv
`default_nettype none
`timescale 1ns/10ps

module opm_lo_regs (
    input  wire                             i_EMUCLK,
    input  wire                             mrst_n,
    input  wire opm_bus_pkg::bus_load_t     i_bus_ld,
    output opm_reg_pkg::timer_regs_t        o_timer,
    output opm_reg_pkg::timer_frst_t        o_timer_frst,
    output opm_reg_pkg::lfo_regs_t          o_lfo,
    output opm_reg_pkg::noise_regs_t        o_noise,
    output logic                            o_lfrq_update
);

logic [opm_bus_pkg::BUS_W-1:0]  din;
logic                           addr_hit;   // byte is a known low address
opm_bus_pkg::lo_addr_e          lo_sel;
logic                           lo_sel_vld;
logic                           reg_wr;

assign din    = i_bus_ld.data;
assign reg_wr = i_bus_ld.data_ld & lo_sel_vld;

////////////////////////////////////////
// address decode

always_comb begin
    case (din)
        opm_bus_pkg::LO_NOISE,
        opm_bus_pkg::LO_CLKA1,
        opm_bus_pkg::LO_CLKA2,
        opm_bus_pkg::LO_CLKB,
        opm_bus_pkg::LO_TIMER_CTRL,
        opm_bus_pkg::LO_LFRQ,
        opm_bus_pkg::LO_PMD_AMD,
        opm_bus_pkg::LO_WAVE:   addr_hit = 1'b1;
        default:                addr_hit = 1'b0;
    endcase
end

// valid stays until the next address byte
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        lo_sel     <= opm_bus_pkg::LO_NOISE;
        lo_sel_vld <= 1'b0;
    end else if (i_bus_ld.addr_ld) begin
        lo_sel     <= opm_bus_pkg::lo_addr_e'(din);
        lo_sel_vld <= addr_hit;
    end
end

////////////////////////////////////////
// global registers

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        o_timer       <= '0;
        o_timer_frst  <= '0;
        o_lfo         <= '0;
        o_noise       <= '0;
        o_lfrq_update <= 1'b0;
    end else begin
        o_timer_frst  <= '0;    // pulses last one clock
        o_lfrq_update <= 1'b0;
        if (reg_wr) begin
            case (lo_sel)
                opm_bus_pkg::LO_NOISE: begin
                    o_noise.ne   <= din[7];
                    o_noise.nfrq <= din[4:0];
                end
                opm_bus_pkg::LO_CLKA1: o_timer.clka1 <= din;
                opm_bus_pkg::LO_CLKA2: o_timer.clka2 <= din[1:0];
                opm_bus_pkg::LO_CLKB:  o_timer.clkb  <= din;
                opm_bus_pkg::LO_TIMER_CTRL: begin
                    o_timer.run_a       <= din[0];
                    o_timer.run_b       <= din[1];
                    o_timer.irq_en_a    <= din[2];
                    o_timer.irq_en_b    <= din[3];
                    o_timer_frst.frst_a <= din[4];  // flag reset only when set
                    o_timer_frst.frst_b <= din[5];
                end
                opm_bus_pkg::LO_LFRQ: begin
                    o_lfo.lfrq    <= din;
                    o_lfrq_update <= 1'b1;
                end
                opm_bus_pkg::LO_PMD_AMD: begin
                    if (din[7]) o_lfo.pmd <= din[6:0];
                    else        o_lfo.amd <= din[6:0];
                end
                opm_bus_pkg::LO_WAVE:  o_lfo.w <= din[1:0];
                default: ;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// File: opm_ch_regs.sv
`default_nettype none
`timescale 1ns/10ps

module opm_ch_regs (
    input  wire                                 i_EMUCLK,
    input  wire                                 mrst_n,
    input  wire opm_bus_pkg::bus_load_t         i_bus_ld,
    output opm_reg_pkg::ch_params_t             o_ch,
    output logic [opm_reg_pkg::CH_W-1:0]        o_ch_slot
);

logic [opm_bus_pkg::BUS_W-1:0]  din;
logic                           ch_addr_hit;
opm_reg_pkg::ch_field_e         fld_q;      // field group of held address
logic [opm_reg_pkg::CH_W-1:0]   ch_q;       // channel of held address
logic                           addr_vld;
logic [opm_bus_pkg::BUS_W-1:0]  data_q;
logic                           data_vld;
logic [opm_reg_pkg::CH_W-1:0]   slot_q;
logic                           slot_hit;
opm_reg_pkg::ch_params_t        ch_sr [opm_reg_pkg::NUM_CH];
opm_reg_pkg::ch_params_t        ch_tail;
opm_reg_pkg::ch_params_t        ch_next;

assign din         = i_bus_ld.data;
assign ch_addr_hit = (din[7:5] == opm_reg_pkg::CH_BLOCK_BASE[7:5]);

////////////////////////////////////////
// temporary address / data

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        fld_q    <= opm_reg_pkg::FLD_CONNECT;
        ch_q     <= '0;
        addr_vld <= 1'b0;
        data_vld <= 1'b0;
    end else if (i_bus_ld.addr_ld) begin
        addr_vld <= ch_addr_hit;    // low address drops it
        data_vld <= 1'b0;
        if (ch_addr_hit) begin
            fld_q <= opm_reg_pkg::ch_field_e'(din[opm_reg_pkg::CH_W+1:opm_reg_pkg::CH_W]);
            ch_q  <= din[opm_reg_pkg::CH_W-1:0];
        end
    end else if (i_bus_ld.data_ld && addr_vld) begin
        data_vld <= 1'b1;
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        data_q <= '0;
    end else if (i_bus_ld.data_ld && addr_vld) begin
        data_q <= din;
    end
end

////////////////////////////////////////
// slot counter and recirculation

// free running, wraps after NUM_CH
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) slot_q <= '0;
    else         slot_q <= slot_q + 1'b1;
end

assign slot_hit = data_vld & (slot_q == ch_q);
assign ch_tail  = ch_sr[opm_reg_pkg::NUM_CH-1];   // belongs to slot_q

// merge held byte into the passing channel
always_comb begin
    ch_next = ch_tail;
    if (slot_hit) begin
        case (fld_q)
            opm_reg_pkg::FLD_CONNECT: begin
                ch_next.rl  = data_q[7:6];
                ch_next.fl  = data_q[5:3];
                ch_next.alg = data_q[2:0];
            end
            opm_reg_pkg::FLD_KC: ch_next.kc = data_q[6:0];
            opm_reg_pkg::FLD_KF: ch_next.kf = data_q[7:2];
            opm_reg_pkg::FLD_PMS_AMS: begin
                ch_next.pms = data_q[6:4];
                ch_next.ams = data_q[1:0];
            end
            default: ;
        endcase
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        for (int i = 0; i < opm_reg_pkg::NUM_CH; i++) ch_sr[i] <= '0;
    end else begin
        ch_sr[0] <= ch_next;
        for (int i = 1; i < opm_reg_pkg::NUM_CH; i++) ch_sr[i] <= ch_sr[i-1];
    end
end

assign o_ch      = ch_tail;
assign o_ch_slot = slot_q;

endmodule

`default_nettype wire

// File: opm_status.sv
`default_nettype none
`timescale 1ns/10ps

module opm_status (
    input  wire                             i_EMUCLK,
    input  wire                             mrst_n,
    input  wire opm_bus_pkg::bus_load_t     i_bus_ld,
    input  wire                             i_cs_n,
    input  wire                             i_rd_n,
    input  wire                             i_a0,
    input  wire                             i_timera_flag,
    input  wire                             i_timerb_flag,
    output logic [opm_bus_pkg::BUS_W-1:0]   o_d,
    output logic                            o_ctrl_oe
);

localparam logic [4:0] BUSY_LAST = 5'(opm_bus_pkg::BUSY_CYCLES - 1);

logic       busy;
logic [4:0] busy_cnt;

// write busy window, restarted by every data byte
always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        busy     <= 1'b0;
        busy_cnt <= '0;
    end else if (i_bus_ld.data_ld) begin
        busy     <= 1'b1;
        busy_cnt <= '0;
    end else if (busy) begin
        if (busy_cnt == BUSY_LAST) busy <= 1'b0;
        busy_cnt <= busy_cnt + 1'b1;
    end
end

assign o_d       = {busy, 5'b00000, i_timera_flag, i_timerb_flag};
assign o_ctrl_oe = ~(i_cs_n | i_rd_n | i_a0);   // status read only

endmodule

`default_nettype wire

// File: opm_reg_top.sv
`default_nettype none
`timescale 1ns/10ps

module opm_reg_top (
    input  wire                             i_EMUCLK,
    input  wire                             mrst_n,

    // host bus
    input  wire                             i_cs_n,
    input  wire                             i_wr_n,
    input  wire                             i_rd_n,
    input  wire                             i_a0,
    input  wire [opm_bus_pkg::BUS_W-1:0]    i_d,
    output wire [opm_bus_pkg::BUS_W-1:0]    o_d,
    output wire                             o_ctrl_oe,

    // timer flags for the status byte
    input  wire                             i_timera_flag,
    input  wire                             i_timerb_flag,

    // register outputs
    output opm_reg_pkg::timer_regs_t        o_timer,
    output opm_reg_pkg::timer_frst_t        o_timer_frst,
    output opm_reg_pkg::lfo_regs_t          o_lfo,
    output opm_reg_pkg::noise_regs_t        o_noise,
    output wire                             o_lfrq_update,
    output opm_reg_pkg::ch_params_t         o_ch,
    output wire [opm_reg_pkg::CH_W-1:0]     o_ch_slot
);

opm_bus_pkg::bus_load_t bus_ld;

////////////////////////////////////////
// bus side

opm_bus_sync u_bus_sync (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_cs_n   (i_cs_n),
    .i_wr_n   (i_wr_n),
    .i_a0     (i_a0),
    .i_d      (i_d),
    .o_bus_ld (bus_ld)
);

opm_status u_status (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_bus_ld      (bus_ld),
    .i_cs_n        (i_cs_n),
    .i_rd_n        (i_rd_n),
    .i_a0          (i_a0),
    .i_timera_flag (i_timera_flag),
    .i_timerb_flag (i_timerb_flag),
    .o_d           (o_d),
    .o_ctrl_oe     (o_ctrl_oe)
);

////////////////////////////////////////
// register banks

opm_lo_regs u_lo_regs (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_bus_ld      (bus_ld),
    .o_timer       (o_timer),
    .o_timer_frst  (o_timer_frst),
    .o_lfo         (o_lfo),
    .o_noise       (o_noise),
    .o_lfrq_update (o_lfrq_update)
);

opm_ch_regs u_ch_regs (
    .i_EMUCLK  (i_EMUCLK),
    .mrst_n    (mrst_n),
    .i_bus_ld  (bus_ld),
    .o_ch      (o_ch),
    .o_ch_slot (o_ch_slot)
);

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

localparam realtime HALF_PERIOD = 4ns;     // 8 ns clock
localparam int      RST_CYCLES  = 8;

initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
end

// release away from the rising edge
initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
end

endmodule

`default_nettype wire

// File: tb_opm_reg.sv
`default_nettype none
`timescale 1ns/10ps

module tb_opm_reg;

localparam int WR_CYCLES = 10;     // strobe plus idle of one bus write
// reset, low regs, timer ctrl, channels, status, random channels
localparam int WATCHDOG_CYCLES = 1000 + 2000 + 2000 + 3000 + 2000 + 10000;

wire                            clk;
wire                            rst_n;
logic                           cs_n;
logic                           wr_n;
logic                           rd_n;
logic                           a0;
logic [7:0]                     d_in;
logic                           timera_flag;
logic                           timerb_flag;
wire  [7:0]                     d_out;
wire                            ctrl_oe;
wire                            lfrq_update;
wire  [opm_reg_pkg::CH_W-1:0]   ch_slot;
opm_reg_pkg::timer_regs_t       timer;
opm_reg_pkg::timer_frst_t       timer_frst;
opm_reg_pkg::lfo_regs_t         lfo;
opm_reg_pkg::noise_regs_t       noise;
opm_reg_pkg::ch_params_t        ch;

// register model
opm_reg_pkg::timer_regs_t       timer_m;
opm_reg_pkg::lfo_regs_t         lfo_m;
opm_reg_pkg::noise_regs_t       noise_m;
opm_reg_pkg::ch_params_t        ch_m [opm_reg_pkg::NUM_CH];
logic [7:0]                     cur_addr;   // last address byte written
logic [opm_reg_pkg::CH_W-1:0]   slot_exp;   // channel due on the slot output

int err_cnt;
int lfrq_pulses;
int frst_a_pulses;
int frst_b_pulses;
int seed = 32'hcfd4_7543;

tb_clkgen u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
);

opm_reg_top dut (
    .i_EMUCLK      (clk),
    .mrst_n        (rst_n),
    .i_cs_n        (cs_n),
    .i_wr_n        (wr_n),
    .i_rd_n        (rd_n),
    .i_a0          (a0),
    .i_d           (d_in),
    .o_d           (d_out),
    .o_ctrl_oe     (ctrl_oe),
    .i_timera_flag (timera_flag),
    .i_timerb_flag (timerb_flag),
    .o_timer       (timer),
    .o_timer_frst  (timer_frst),
    .o_lfo         (lfo),
    .o_noise       (noise),
    .o_lfrq_update (lfrq_update),
    .o_ch          (ch),
    .o_ch_slot     (ch_slot)
);

// pulses last a full cycle, so one sample each
always @(negedge clk) begin
    if (lfrq_update)       lfrq_pulses++;
    if (timer_frst.frst_a) frst_a_pulses++;
    if (timer_frst.frst_b) frst_b_pulses++;
end

// slot steps once per clock from reset, 0 through 7
always @(posedge clk) begin
    if (!rst_n) slot_exp <= '0;
    else        slot_exp <= slot_exp + 1'b1;
end

////////////////////////////////////////
// compare tasks

task automatic check_timer(input string name, input opm_reg_pkg::timer_regs_t exp,
                           input opm_reg_pkg::timer_regs_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: timer expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_lfo(input string name, input opm_reg_pkg::lfo_regs_t exp,
                         input opm_reg_pkg::lfo_regs_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: lfo expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_noise(input string name, input opm_reg_pkg::noise_regs_t exp,
                           input opm_reg_pkg::noise_regs_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: noise expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_ch(input string name, input opm_reg_pkg::ch_params_t exp,
                        input opm_reg_pkg::ch_params_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: slot %0d expected %h, actual %h", name, ch_slot, exp, act);
    end
endtask

task automatic check_slot(input string name, input logic [opm_reg_pkg::CH_W-1:0] exp,
                          input logic [opm_reg_pkg::CH_W-1:0] act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: slot expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: status expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_cnt++;
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        err_cnt++;
        $display("ERROR %s: expected %0d pulses, actual %0d", name, exp, act);
    end
endtask

////////////////////////////////////////
// model and bus helpers

task automatic model_data(input logic [7:0] data);
    int idx;
    idx = cur_addr[2:0];
    if (cur_addr[7:5] == opm_reg_pkg::CH_BLOCK_BASE[7:5]) begin
        case (cur_addr[4:3])
            opm_reg_pkg::FLD_CONNECT: begin
                ch_m[idx].rl  = data[7:6];
                ch_m[idx].fl  = data[5:3];
                ch_m[idx].alg = data[2:0];
            end
            opm_reg_pkg::FLD_KC: ch_m[idx].kc = data[6:0];
            opm_reg_pkg::FLD_KF: ch_m[idx].kf = data[7:2];
            default: begin
                ch_m[idx].pms = data[6:4];
                ch_m[idx].ams = data[1:0];
            end
        endcase
    end else begin
        case (cur_addr)
            opm_bus_pkg::LO_NOISE: begin
                noise_m.ne   = data[7];
                noise_m.nfrq = data[4:0];
            end
            opm_bus_pkg::LO_CLKA1: timer_m.clka1 = data;
            opm_bus_pkg::LO_CLKA2: timer_m.clka2 = data[1:0];
            opm_bus_pkg::LO_CLKB:  timer_m.clkb  = data;
            opm_bus_pkg::LO_TIMER_CTRL: begin
                timer_m.run_a    = data[0];
                timer_m.run_b    = data[1];
                timer_m.irq_en_a = data[2];
                timer_m.irq_en_b = data[3];
            end
            opm_bus_pkg::LO_LFRQ: lfo_m.lfrq = data;
            opm_bus_pkg::LO_PMD_AMD: begin
                if (data[7]) lfo_m.pmd = data[6:0];
                else         lfo_m.amd = data[6:0];
            end
            opm_bus_pkg::LO_WAVE: lfo_m.w = data[1:0];
            default: ;  // unmapped address, nothing held
        endcase
    end
endtask

task automatic bus_write(input logic sel_a0, input logic [7:0] data);
    @(negedge clk);
    cs_n = 1'b0;
    wr_n = 1'b0;
    a0   = sel_a0;
    d_in = data;
    repeat (2) @(negedge clk);
    cs_n = 1'b1;
    wr_n = 1'b1;
    repeat (8) @(negedge clk);  // load pulse lands in here
    if (sel_a0) model_data(data);
    else        cur_addr = data;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    bus_write(1'b0, addr);
    bus_write(1'b1, data);
endtask

task automatic write_ch(input opm_reg_pkg::ch_field_e fld, input int chn,
                        input logic [7:0] data);
    write_reg(opm_reg_pkg::CH_BLOCK_BASE | {3'b000, fld, 3'(chn)}, data);
endtask

task automatic check_lo(input string name);
    check_timer(name, timer_m, timer);
    check_lfo(name, lfo_m, lfo);
    check_noise(name, noise_m, noise);
endtask

// two rotations to settle, then one full scan
task automatic check_channels(input string name);
    repeat (2 * opm_reg_pkg::NUM_CH) @(negedge clk);
    repeat (opm_reg_pkg::NUM_CH) begin
        @(negedge clk);
        check_slot(name, slot_exp, ch_slot);
        check_ch(name, ch_m[slot_exp], ch);
    end
endtask

task automatic read_status(input string name, input logic exp_busy);
    logic [7:0] exp;
    exp = {exp_busy, 5'b00000, timera_flag, timerb_flag};
    @(negedge clk);
    cs_n = 1'b0;
    rd_n = 1'b0;
    a0   = 1'b0;
    @(negedge clk);
    check_bit({name, " oe"}, 1'b1, ctrl_oe);
    check_byte(name, exp, d_out);
    cs_n = 1'b1;
    rd_n = 1'b1;
endtask

////////////////////////////////////////
// tests

task automatic test_reset();
    check_lo("reset");
    check_bit("reset idle oe", 1'b0, ctrl_oe);
    check_channels("reset channels");
    read_status("reset status", 1'b0);
endtask

task automatic test_lo_regs();
    logic [7:0] addrs [6];
    logic [7:0] data;
    addrs = '{opm_bus_pkg::LO_NOISE, opm_bus_pkg::LO_CLKA1, opm_bus_pkg::LO_CLKA2,
              opm_bus_pkg::LO_CLKB, opm_bus_pkg::LO_LFRQ, opm_bus_pkg::LO_WAVE};
    foreach (addrs[i]) begin
        lfrq_pulses = 0;
        data = $random(seed);
        write_reg(addrs[i], data);
        check_lo($sformatf("lo write %h", addrs[i]));
        check_count($sformatf("lfrq update %h", addrs[i]),
                    (addrs[i] == opm_bus_pkg::LO_LFRQ) ? 1 : 0, lfrq_pulses);
    end
    data = $random(seed);
    write_reg(opm_bus_pkg::LO_PMD_AMD, data | 8'h80);
    check_lo("pmd write");
    data = $random(seed);
    write_reg(opm_bus_pkg::LO_PMD_AMD, data & 8'h7F);
    check_lo("amd write");
endtask

task automatic test_timer_ctrl();
    logic [7:0] vals [4];
    vals = '{8'h3F, 8'h05, 8'h1A, 8'h2C};   // both, none, a only, b only
    foreach (vals[i]) begin
        frst_a_pulses = 0;
        frst_b_pulses = 0;
        write_reg(opm_bus_pkg::LO_TIMER_CTRL, vals[i]);
        check_lo($sformatf("timer ctrl %h", vals[i]));
        check_count($sformatf("frst_a %h", vals[i]), int'(vals[i][4]), frst_a_pulses);
        check_count($sformatf("frst_b %h", vals[i]), int'(vals[i][5]), frst_b_pulses);
    end
endtask

task automatic test_ch_regs();
    write_ch(opm_reg_pkg::FLD_CONNECT, 0, 8'hC5);
    write_ch(opm_reg_pkg::FLD_KC, 3, 8'h4A);
    write_ch(opm_reg_pkg::FLD_KF, 5, 8'hFC);
    write_ch(opm_reg_pkg::FLD_PMS_AMS, 7, 8'h73);
    write_ch(opm_reg_pkg::FLD_CONNECT, 5, 8'h9E);
    write_ch(opm_reg_pkg::FLD_KC, 1, 8'h7F);
    write_ch(opm_reg_pkg::FLD_KF, 2, 8'h58);
    write_ch(opm_reg_pkg::FLD_PMS_AMS, 2, 8'h52);
    check_channels("ch writes");
    repeat (3 * opm_reg_pkg::NUM_CH) @(negedge clk);
    check_channels("ch persist");
    // data after a low address must not reach ch2
    bus_write(1'b0, opm_bus_pkg::LO_NOISE);
    bus_write(1'b1, 8'h9A);
    check_channels("ch after lo addr");
    check_lo("noise after ch");
endtask

task automatic test_status();
    repeat (opm_bus_pkg::BUSY_CYCLES + 4) @(negedge clk);  // older busy window ends
    for (int i = 0; i < 8; i++) begin
        cs_n = i[2];
        rd_n = i[1];
        a0   = i[0];
        @(negedge clk);
        check_bit($sformatf("oe combo %0d", i), (i == 0), ctrl_oe);
    end
    cs_n = 1'b1;
    rd_n = 1'b1;
    a0   = 1'b0;
    for (int f = 0; f < 4; f++) begin
        timera_flag = f[1];
        timerb_flag = f[0];
        read_status($sformatf("flags %0d", f), 1'b0);
    end
    timera_flag = 1'b0;
    timerb_flag = 1'b0;
    write_reg(opm_bus_pkg::LO_CLKB, 8'h5A);
    read_status("busy high", 1'b1);
    repeat (opm_bus_pkg::BUSY_CYCLES + 4 - WR_CYCLES) @(negedge clk);
    read_status("busy low", 1'b0);
endtask

task automatic test_random_ch();
    logic [31:0]             rnd;
    int                      chn;
    opm_reg_pkg::ch_field_e  fld;
    logic [7:0]              data;
    repeat (40) begin
        rnd  = $random(seed);
        chn  = rnd[2:0];
        fld  = opm_reg_pkg::ch_field_e'(rnd[4:3]);
        data = rnd[15:8];
        write_ch(fld, chn, data);
        check_channels($sformatf("random ch%0d fld%0d", chn, fld));
    end
endtask

////////////////////////////////////////
// run control

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
end

initial begin
    cs_n          = 1'b1;
    wr_n          = 1'b1;
    rd_n          = 1'b1;
    a0            = 1'b0;
    d_in          = '0;
    timera_flag   = 1'b0;
    timerb_flag   = 1'b0;
    timer_m       = '0;
    lfo_m         = '0;
    noise_m       = '0;
    cur_addr      = '0;
    err_cnt       = 0;
    lfrq_pulses   = 0;
    frst_a_pulses = 0;
    frst_b_pulses = 0;
    for (int i = 0; i < opm_reg_pkg::NUM_CH; i++) ch_m[i] = '0;

    @(posedge rst_n);
    @(negedge clk);
    test_reset();
    test_lo_regs();
    test_timer_ctrl();
    test_ch_regs();
    test_status();
    test_random_ch();

    $display("tests done, error count %0d", err_cnt);
    if (err_cnt == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: sources.f
opm_bus_pkg.sv
opm_reg_pkg.sv
opm_bus_sync.sv
opm_lo_regs.sv
opm_ch_regs.sv
opm_status.sv
opm_reg_top.sv
tb_clkgen.sv
tb_opm_reg.sv

// File: Bender.yml
package:
  name: opm_reg

sources:
  - opm_bus_pkg.sv
  - opm_reg_pkg.sv
  - opm_bus_sync.sv
  - opm_lo_regs.sv
  - opm_ch_regs.sv
  - opm_status.sv
  - opm_reg_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_opm_reg.sv
